/* verilog/arp_pkg.sv */
`default_nettype none

package arp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] oper_t;

    // ethernet header
    localparam logic [15:0] ETH_TYPE_ARP  = 16'h0806;
    localparam mac_addr_t   BROADCAST_MAC = 48'hFFFF_FFFF_FFFF;
    localparam int          ETH_HDR_LEN   = 14;
    localparam int          ETH_OFS_SRC   = 6;
    localparam int          ETH_OFS_TYPE  = 12;

    // arp body, offsets relative to its first byte
    localparam int ARP_BODY_LEN      = 28;
    localparam int ARP_OFS_OPER      = 6;
    localparam int ARP_OFS_SENDER_IP = 14;
    localparam int ARP_OFS_TARGET_IP = 24;

    localparam oper_t ARP_OPER_REQUEST = 16'd1;
    localparam oper_t ARP_OPER_REPLY   = 16'd2;

    // fixed reply fields
    localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
    localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
    localparam byte_t       ARP_HLEN_ETH   = 8'd6;
    localparam byte_t       ARP_PLEN_IPV4  = 8'd4;

    // 42 data bytes, rest is zero padding
    localparam int REPLY_LEN = 60;

endpackage

`default_nettype wire

/* verilog/arp_req_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface arp_req_if;

    logic                done;
    arp_pkg::oper_t      oper;
    arp_pkg::mac_addr_t  sender_mac;
    arp_pkg::ip_addr_t   sender_ip;
    arp_pkg::ip_addr_t   target_ip;

    modport decode (
        output done, oper, sender_mac, sender_ip, target_ip
    );

    modport match (
        input done, oper, target_ip
    );

    // peer addresses for the reply
    modport reply (
        input sender_mac, sender_ip
    );

endinterface

`default_nettype wire

/* verilog/arp_frame_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module arp_frame_decode (
    input  wire                  sys_clk,
    input  wire                  sys_rst_n,
    input  wire                  rx_sop,
    input  wire                  rx_eop,
    input  wire                  rx_vld,
    input  wire arp_pkg::byte_t  rx_dat,
    arp_req_if.decode            req
);

    localparam int LAST_IDX = arp_pkg::ETH_HDR_LEN + arp_pkg::ARP_BODY_LEN - 1;
    localparam int OPER_IDX = arp_pkg::ETH_HDR_LEN + arp_pkg::ARP_OFS_OPER;
    localparam int SIP_IDX  = arp_pkg::ETH_HDR_LEN + arp_pkg::ARP_OFS_SENDER_IP;
    localparam int TIP_IDX  = arp_pkg::ETH_HDR_LEN + arp_pkg::ARP_OFS_TARGET_IP;

    logic [5:0]          byte_cnt;
    logic [5:0]          idx;
    logic                take;
    logic                last_seen;
    logic                done;
    arp_pkg::mac_addr_t  dst_mac;
    arp_pkg::mac_addr_t  src_mac;
    logic [15:0]         eth_type;
    arp_pkg::oper_t      oper;
    arp_pkg::ip_addr_t   sender_ip;
    arp_pkg::ip_addr_t   target_ip;

    function automatic logic in_field(input logic [5:0] pos, input int ofs, input int len);
        return (int'(pos) >= ofs) && (int'(pos) < ofs + len);
    endfunction

    // counter sits at 0 between frames, only sop opens one
    assign idx  = rx_sop ? 6'd0 : byte_cnt;
    assign take = rx_vld && (rx_sop || (byte_cnt != 6'd0));

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            byte_cnt <= 6'd0;
        end else if (rx_vld && rx_eop) begin
            byte_cnt <= 6'd0;
        end else if (rx_vld && rx_sop) begin
            byte_cnt <= 6'd1;
        end else if (take && (byte_cnt != 6'h3f)) begin
            byte_cnt <= byte_cnt + 6'd1;
        end
    end

    // fields shift in msb first
    always_ff @(posedge sys_clk) begin
        if (take && in_field(idx, 0, 6)) begin
            dst_mac <= {dst_mac[39:0], rx_dat};
        end
        if (take && in_field(idx, arp_pkg::ETH_OFS_SRC, 6)) begin
            src_mac <= {src_mac[39:0], rx_dat};
        end
        if (take && in_field(idx, arp_pkg::ETH_OFS_TYPE, 2)) begin
            eth_type <= {eth_type[7:0], rx_dat};
        end
        if (take && in_field(idx, OPER_IDX, 2)) begin
            oper <= {oper[7:0], rx_dat};
        end
        if (take && in_field(idx, SIP_IDX, 4)) begin
            sender_ip <= {sender_ip[23:0], rx_dat};
        end
        if (take && in_field(idx, TIP_IDX, 4)) begin
            target_ip <= {target_ip[23:0], rx_dat};
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            last_seen <= 1'b0;
            done      <= 1'b0;
        end else begin
            last_seen <= take && (int'(idx) == LAST_IDX);
            done      <= last_seen && (dst_mac == arp_pkg::BROADCAST_MAC)
                         && (eth_type == arp_pkg::ETH_TYPE_ARP);
        end
    end

    assign req.done       = done;
    assign req.oper       = oper;
    assign req.sender_mac = src_mac;
    assign req.sender_ip  = sender_ip;
    assign req.target_ip  = target_ip;

endmodule

`default_nettype wire

/* verilog/arp_request_match.sv */
`timescale 1ns/10ps
`default_nettype none

module arp_request_match #(
    parameter arp_pkg::mac_addr_t RESET_MAC_ADDR = 48'h0,
    parameter arp_pkg::ip_addr_t  RESET_IP_ADDR  = 32'hC0A8_01F0
) (
    input  wire                      sys_clk,
    input  wire                      sys_rst_n,
    input  wire                      load_vld,
    input  wire arp_pkg::mac_addr_t  load_mac,
    input  wire arp_pkg::ip_addr_t   load_ip,
    arp_req_if.match                 req,
    output logic                     reply_start,
    output arp_pkg::mac_addr_t       station_mac,
    output arp_pkg::ip_addr_t        station_ip
);

    // station addresses, loaded at run time
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            station_mac <= RESET_MAC_ADDR;
            station_ip  <= RESET_IP_ADDR;
        end else if (load_vld) begin
            station_mac <= load_mac;
            station_ip  <= load_ip;
        end
    end

    // request for our ip
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            reply_start <= 1'b0;
        end else begin
            reply_start <= req.done
                           && (req.oper == arp_pkg::ARP_OPER_REQUEST)
                           && (req.target_ip == station_ip);
        end
    end

endmodule

`default_nettype wire

/* verilog/arp_reply_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module arp_reply_gen (
    input  wire                      sys_clk,
    input  wire                      sys_rst_n,
    input  wire                      reply_start,
    input  wire arp_pkg::mac_addr_t  station_mac,
    input  wire arp_pkg::ip_addr_t   station_ip,
    arp_req_if.reply                 req,
    output logic                     tx_sop,
    output logic                     tx_eop,
    output logic                     tx_vld,
    output arp_pkg::byte_t           tx_dat
);

    localparam int         HDR_BYTES = arp_pkg::ETH_HDR_LEN + arp_pkg::ARP_BODY_LEN;
    localparam logic [5:0] LAST_IDX  = 6'(arp_pkg::REPLY_LEN - 1);

    logic                    busy;
    logic [5:0]              idx;
    arp_pkg::mac_addr_t      peer_mac;
    arp_pkg::ip_addr_t       peer_ip;
    logic [8*HDR_BYTES-1:0]  hdr;
    arp_pkg::byte_t          sel_byte;

    // ethernet header then arp body, first byte at the top
    assign hdr = {peer_mac, station_mac, arp_pkg::ETH_TYPE_ARP,
                  arp_pkg::ARP_HTYPE_ETH, arp_pkg::ARP_PTYPE_IPV4,
                  arp_pkg::ARP_HLEN_ETH, arp_pkg::ARP_PLEN_IPV4,
                  arp_pkg::ARP_OPER_REPLY, station_mac, station_ip,
                  peer_mac, peer_ip};

    always_comb begin
        if (int'(idx) < HDR_BYTES) begin
            sel_byte = hdr[8*(HDR_BYTES-1-int'(idx)) +: 8];
        end else begin
            sel_byte = 8'h00;
        end
    end

    // starts while busy are dropped
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            busy <= 1'b0;
            idx  <= 6'd0;
        end else if (!busy && reply_start) begin
            busy <= 1'b1;
            idx  <= 6'd0;
        end else if (busy && (idx == LAST_IDX)) begin
            busy <= 1'b0;
            idx  <= 6'd0;
        end else if (busy) begin
            idx <= idx + 6'd1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!busy && reply_start) begin
            peer_mac <= req.sender_mac;
            peer_ip  <= req.sender_ip;
        end
    end

    // output stage
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            tx_sop <= 1'b0;
            tx_eop <= 1'b0;
            tx_vld <= 1'b0;
            tx_dat <= 8'h00;
        end else begin
            tx_sop <= busy && (idx == 6'd0);
            tx_eop <= busy && (idx == LAST_IDX);
            tx_vld <= busy;
            tx_dat <= busy ? sel_byte : 8'h00;
        end
    end

endmodule

`default_nettype wire

/* verilog/arp_responder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module arp_responder_top #(
    parameter arp_pkg::mac_addr_t RESET_MAC_ADDR = 48'h0,
    parameter arp_pkg::ip_addr_t  RESET_IP_ADDR  = 32'hC0A8_01F0
) (
    input  wire                      sys_clk,
    input  wire                      sys_rst_n,

    input  wire                      load_parameter_vld,
    input  wire arp_pkg::mac_addr_t  lidar_mac_address,
    input  wire arp_pkg::ip_addr_t   lidar_ip_address,

    // receive stream, msb first
    input  wire                      mac_packet_rx_sop,
    input  wire                      mac_packet_rx_eop,
    input  wire                      mac_packet_rx_vld,
    input  wire arp_pkg::byte_t      mac_packet_rx_dat,

    output logic                     arp_tx_sop,
    output logic                     arp_tx_eop,
    output logic                     arp_tx_vld,
    output arp_pkg::byte_t           arp_tx_dat
);

    logic                reply_start;
    arp_pkg::mac_addr_t  station_mac;
    arp_pkg::ip_addr_t   station_ip;

    arp_req_if req_bus ();

    arp_frame_decode u_decode (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rx_sop    (mac_packet_rx_sop),
        .rx_eop    (mac_packet_rx_eop),
        .rx_vld    (mac_packet_rx_vld),
        .rx_dat    (mac_packet_rx_dat),
        .req       (req_bus.decode)
    );

    arp_request_match #(
        .RESET_MAC_ADDR (RESET_MAC_ADDR),
        .RESET_IP_ADDR  (RESET_IP_ADDR)
    ) u_match (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .load_vld    (load_parameter_vld),
        .load_mac    (lidar_mac_address),
        .load_ip     (lidar_ip_address),
        .req         (req_bus.match),
        .reply_start (reply_start),
        .station_mac (station_mac),
        .station_ip  (station_ip)
    );

    arp_reply_gen u_reply (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .reply_start (reply_start),
        .station_mac (station_mac),
        .station_ip  (station_ip),
        .req         (req_bus.reply),
        .tx_sop      (arp_tx_sop),
        .tx_eop      (arp_tx_eop),
        .tx_vld      (arp_tx_vld),
        .tx_dat      (arp_tx_dat)
    );

endmodule

`default_nettype wire

/* bench/arp_responder_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module arp_responder_assertions (
    input wire sys_clk,
    input wire sys_rst_n,
    input wire arp_tx_sop,
    input wire arp_tx_eop,
    input wire arp_tx_vld
);

    int         fail_count = 0;
    logic [5:0] left;

    // bytes of the reply still to come after this cycle
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            left <= 6'd0;
        end else if (arp_tx_sop) begin
            left <= 6'd59;
        end else if (left != 6'd0) begin
            left <= left - 6'd1;
        end
    end

    markers_need_vld: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (arp_tx_sop || arp_tx_eop) |-> arp_tx_vld)
    else begin
        fail_count++;
        $error("sop or eop without vld");
    end

    // eop on the 60th byte, vld all the way
    reply_span: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (arp_tx_sop || (left != 6'd0)) |-> (arp_tx_vld && (arp_tx_eop == (left == 6'd1))))
    else begin
        fail_count++;
        $error("reply span broken, vld low or eop not 59 cycles after sop");
    end

    vld_only_in_span: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        arp_tx_vld |-> (arp_tx_sop || (left != 6'd0)))
    else begin
        fail_count++;
        $error("vld high outside a reply");
    end

endmodule

bind arp_responder_top arp_responder_assertions u_assertions (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .arp_tx_sop (arp_tx_sop),
    .arp_tx_eop (arp_tx_eop),
    .arp_tx_vld (arp_tx_vld)
);

`default_nettype wire

/* bench/arp_responder_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module arp_responder_tb;

    localparam int              CLK_PERIOD  = 40;
    localparam logic [31:0]     SEED        = 32'd30;
    localparam int              FRAME_GAP   = 70;
    localparam int              NUM_FRAMES  = 31;
    localparam int              CYCLE_LIMIT = NUM_FRAMES * 130 + 200;
    localparam arp_pkg::mac_addr_t BCAST    = 48'hFFFF_FFFF_FFFF;
    localparam arp_pkg::mac_addr_t ST_MAC   = 48'h02_11_22_33_44_55;

    logic                sys_clk;
    logic                sys_rst_n;
    logic                load_parameter_vld;
    arp_pkg::mac_addr_t  lidar_mac_address;
    arp_pkg::ip_addr_t   lidar_ip_address;
    logic                rx_sop;
    logic                rx_eop;
    logic                rx_vld;
    arp_pkg::byte_t      rx_dat;
    logic                tx_sop;
    logic                tx_eop;
    logic                tx_vld;
    arp_pkg::byte_t      tx_dat;

    int                  cycle = 0;
    int                  errors = 0;
    logic [31:0]         rng = SEED;
    // model copy of the station registers
    arp_pkg::mac_addr_t  st_mac = 48'h0;
    arp_pkg::ip_addr_t   st_ip = 32'hC0A8_01F0;
    int                  last_sop = -1000;
    logic [479:0]        exp_q[$];
    int                  exp_cyc_q[$];

    arp_responder_top DUT (
        .sys_clk            (sys_clk),
        .sys_rst_n          (sys_rst_n),
        .load_parameter_vld (load_parameter_vld),
        .lidar_mac_address  (lidar_mac_address),
        .lidar_ip_address   (lidar_ip_address),
        .mac_packet_rx_sop  (rx_sop),
        .mac_packet_rx_eop  (rx_eop),
        .mac_packet_rx_vld  (rx_vld),
        .mac_packet_rx_dat  (rx_dat),
        .arp_tx_sop         (tx_sop),
        .arp_tx_eop         (tx_eop),
        .arp_tx_vld         (tx_vld),
        .arp_tx_dat         (tx_dat)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycle = cycle + 1;
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 42 data bytes then 18 bytes of zero padding
    function automatic logic [479:0] ref_reply(input arp_pkg::mac_addr_t peer_mac,
                                               input arp_pkg::ip_addr_t peer_ip,
                                               input arp_pkg::mac_addr_t sm,
                                               input arp_pkg::ip_addr_t sip);
        return {peer_mac, sm, 16'h0806, 16'h0001, 16'h0800, 8'd6, 8'd4, 16'd2,
                sm, sip, peer_mac, peer_ip, 144'h0};
    endfunction

    task automatic load_station(input arp_pkg::mac_addr_t mac, input arp_pkg::ip_addr_t ip);
        @(negedge sys_clk);
        load_parameter_vld = 1'b1;
        lidar_mac_address  = mac;
        lidar_ip_address   = ip;
        @(negedge sys_clk);
        load_parameter_vld = 1'b0;
        st_mac = mac;
        st_ip  = ip;
    endtask

    task automatic send_frame(input arp_pkg::mac_addr_t dst, input logic [15:0] etype,
                              input arp_pkg::oper_t oper, input arp_pkg::mac_addr_t peer_mac,
                              input arp_pkg::ip_addr_t peer_ip, input arp_pkg::ip_addr_t tgt_ip,
                              input int nbytes, input int gap);
        logic [335:0] frame;
        int           last_cyc;
        int           i;
        frame = {dst, peer_mac, etype, 16'h0001, 16'h0800, 8'd6, 8'd4, oper,
                 peer_mac, peer_ip, 48'h0, tgt_ip};
        last_cyc = -1;
        for (i = 0; i < nbytes; i++) begin
            @(negedge sys_clk);
            rx_vld = 1'b1;
            rx_sop = (i == 0);
            rx_eop = (i == nbytes - 1);
            rx_dat = frame[335 - 8 * i -: 8];
            if (i == 41) begin
                last_cyc = cycle;
            end
        end
        @(negedge sys_clk);
        rx_vld = 1'b0;
        rx_sop = 1'b0;
        rx_eop = 1'b0;
        rx_dat = 8'h00;
        // full broadcast request for our ip that finds the generator idle
        if ((last_cyc >= 0) && (dst == BCAST) && (etype == 16'h0806) && (oper == 16'd1)
            && (tgt_ip == st_ip) && (last_cyc + 5 >= last_sop + 61)) begin
            exp_q.push_back(ref_reply(peer_mac, peer_ip, st_mac, st_ip));
            exp_cyc_q.push_back(last_cyc + 5);
            last_sop = last_cyc + 5;
        end
        repeat (gap - 1) @(negedge sys_clk);
    endtask

    initial begin : comparator
        arp_pkg::byte_t got[$];
        logic [479:0]   want;
        int             want_cyc;
        int             sop_cyc;
        logic           in_frame;
        int             i;
        in_frame = 1'b0;
        sop_cyc  = 0;
        forever begin
            @(negedge sys_clk);
            if (tx_vld && tx_sop) begin
                if (in_frame) begin
                    errors++;
                    $display("error at %0t: sop inside a reply", $time);
                end
                got.delete();
                in_frame = 1'b1;
                sop_cyc  = cycle;
            end
            if (tx_vld && !in_frame) begin
                errors++;
                $display("error at %0t: vld outside a reply", $time);
            end else if (tx_vld) begin
                got.push_back(tx_dat);
            end else if (in_frame) begin
                errors++;
                $display("error at %0t: vld dropped after %0d bytes", $time, got.size());
                in_frame = 1'b0;
            end
            if (in_frame && tx_eop) begin
                in_frame = 1'b0;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a reply of %0d bytes was sent that no request asked for",
                             got.size());
                end else begin
                    want     = exp_q.pop_front();
                    want_cyc = exp_cyc_q.pop_front();
                    if (sop_cyc != want_cyc) begin
                        errors++;
                        $display("error at %0t: sop in cycle %0d, expected %0d",
                                 $time, sop_cyc, want_cyc);
                    end
                    if (got.size() != 60) begin
                        errors++;
                        $display("error at %0t: reply length %0d, expected 60",
                                 $time, got.size());
                    end
                    for (i = 0; (i < got.size()) && (i < 60); i++) begin
                        if (got[i] != want[479 - 8 * i -: 8]) begin
                            errors++;
                            $display("error at %0t: byte %0d is %02h, expected %02h",
                                     $time, i, got[i], want[479 - 8 * i -: 8]);
                        end
                    end
                end
            end
        end
    end

    initial begin : stimulus
        arp_pkg::mac_addr_t peer_mac;
        arp_pkg::ip_addr_t  peer_ip;
        arp_pkg::ip_addr_t  tgt_ip;
        int                 assert_fails;
        int                 n;
        sys_rst_n          = 1'b0;
        load_parameter_vld = 1'b0;
        lidar_mac_address  = 48'h0;
        lidar_ip_address   = 32'h0;
        rx_sop             = 1'b0;
        rx_eop             = 1'b0;
        rx_vld             = 1'b0;
        rx_dat             = 8'h00;
        repeat (10) @(negedge sys_clk);
        sys_rst_n = 1'b1;

        // station mac loaded and ip left at its reset value
        load_station(ST_MAC, 32'hC0A8_01F0);
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0C, 32'hC0A8_0105,
                   32'hC0A8_01F0, 42, FRAME_GAP);

        // new ip makes the old one stale
        load_station(ST_MAC, 32'h0A00_0042);
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0D, 32'h0A00_0007,
                   32'hC0A8_01F0, 42, FRAME_GAP);
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0D, 32'h0A00_0007,
                   32'h0A00_0042, 42, FRAME_GAP);

        // one wrong field each
        send_frame(ST_MAC, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0E, 32'h0A00_0008,
                   st_ip, 42, FRAME_GAP);
        send_frame(BCAST, 16'h0800, 16'd1, 48'h00_1B_21_0A_0B_0E, 32'h0A00_0008,
                   st_ip, 42, FRAME_GAP);
        send_frame(BCAST, 16'h0806, 16'd2, 48'h00_1B_21_0A_0B_0E, 32'h0A00_0008,
                   st_ip, 42, FRAME_GAP);
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0E, 32'h0A00_0008,
                   32'h0A00_0043, 42, FRAME_GAP);

        // short frame followed by a full one
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0F, 32'h0A00_0009,
                   st_ip, 30, FRAME_GAP);
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0B_0F, 32'h0A00_0009,
                   st_ip, 42, FRAME_GAP);

        for (n = 0; n < 20; n++) begin
            rng = xorshift32(rng);
            peer_mac[47:32] = rng[15:0];
            rng = xorshift32(rng);
            peer_mac[31:0] = rng;
            rng = xorshift32(rng);
            peer_ip = rng;
            tgt_ip = (n % 4 == 3) ? (st_ip ^ 32'h1) : st_ip;
            send_frame(BCAST, 16'h0806, 16'd1, peer_mac, peer_ip, tgt_ip, 42, FRAME_GAP);
        end

        // second byte 41 lands 45 cycles after the first while the reply runs
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0C_01, 32'h0A00_0011,
                   st_ip, 42, 3);
        send_frame(BCAST, 16'h0806, 16'd1, 48'h00_1B_21_0A_0C_02, 32'h0A00_0012,
                   st_ip, 42, FRAME_GAP);
        repeat (FRAME_GAP) @(negedge sys_clk);

        if (exp_q.size() != 0) begin
            errors += exp_q.size();
            $display("%0d expected replies never appeared on the output", exp_q.size());
        end
        assert_fails = DUT.u_assertions.fail_count;
        $display("checks failed: %0d, assertion failures: %0d", errors, assert_fails);
        if ((errors == 0) && (assert_fails == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/arp_pkg.sv
verilog/arp_req_if.sv
verilog/arp_frame_decode.sv
verilog/arp_request_match.sv
verilog/arp_reply_gen.sv
verilog/arp_responder_top.sv
bench/arp_responder_assertions.sv
bench/arp_responder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= arp_responder_tb
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter-out +%,$(shell cat sources.f))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) sources.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f

run: $(SIM_BIN)
	@$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR)
